// ==== compile.f ====
+incdir+logic
logic/scan_pkg.sv
logic/char_stream_if.sv
logic/mail_dfa.sv
logic/stream_matcher.sv
logic/scan_regs.sv
logic/smtp_scan_top.sv
test/tb_smtp_scan.sv

// ==== logic/char_stream_if.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

interface char_stream_if
  import scan_pkg::*;
();

  // Payload byte and its qualifier
  char_t                     ch;
  logic                      ch_vld;
  // Packet framing
  logic                      load_state;
  logic                      eop;
  // Stream the packet belongs to, held from load_state to eop
  logic [`SCAN_STREAM_W-1:0] stream_id;
  // Sampled with load_state, start from S_IDLE
  logic                      new_stream_id;

  // Packet source, drives the bus
  modport source (
    output ch, ch_vld, load_state, eop, stream_id, new_stream_id
  );

  // Matcher side
  modport sink (
    input ch, ch_vld, load_state, eop, stream_id, new_stream_id
  );

endinterface

// ==== logic/mail_dfa.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

module mail_dfa
  import scan_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  char_t      ch,
  input  logic       ch_vld,
  input  dfa_state_t state_load,
  input  logic       load_vld,
  output dfa_state_t state,
  output logic       accept
);

  // Letters of the pattern, case sensitive
  localparam char_t CH_M = 8'h4D;
  localparam char_t CH_A = 8'h41;
  localparam char_t CH_I = 8'h49;
  localparam char_t CH_L = 8'h4C;

  dfa_state_t state_nxt;

  // Next state for the current character
  always_comb
  begin
    // Mismatch falls back, an M restarts the prefix
    state_nxt = (ch == CH_M) ? S_M : S_IDLE;
    case (state)
      S_M:
      begin
        if (ch == CH_A)
          state_nxt = S_MA;
      end
      S_MA:
      begin
        if (ch == CH_I)
          state_nxt = S_MAI;
      end
      S_MAI:
      begin
        if (ch == CH_L)
          state_nxt = S_HIT;
      end
      // S_IDLE and S_HIT use the fallback rule
      default:
      begin
        state_nxt = (ch == CH_M) ? S_M : S_IDLE;
      end
    endcase
  end

  // State register, restore takes precedence
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state <= S_IDLE;
    else if (load_vld)
      state <= state_load;
    else if (ch_vld)
      state <= state_nxt;
  end

  // Accept while sitting in the final state
  assign accept = (state == S_HIT);

  // Restore and characters come from separate phases of a packet
  assert property (@(posedge clk) disable iff (!rst_n) !(load_vld && ch_vld))
    else $error("mail_dfa: state load and character in the same cycle");

endmodule

// ==== logic/scan_cfg.svh ====
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// Stream id width, must cover SCAN_NUM_STREAMS
`define SCAN_STREAM_W 6

// Depth of the per-stream state memory and width of the enable bitmap
`define SCAN_NUM_STREAMS 64

// Global match counter width
`define SCAN_COUNT_W 16

// APB byte address width, four word registers
`define SCAN_ADDR_W 4

`endif

// ==== logic/scan_pkg.sv ====
`include "scan_cfg.svh"

package scan_pkg;

  // One payload byte
  typedef logic [7:0] char_t;

  // DFA states for the word MAIL
  // Each state names the prefix matched so far
  typedef enum logic [2:0] {
    S_IDLE = 3'd0,
    S_M    = 3'd1,
    S_MA   = 3'd2,
    S_MAI  = 3'd3,
    S_HIT  = 3'd4
  } dfa_state_t;

  // APB register map, word aligned
  typedef enum logic [`SCAN_ADDR_W-1:0] {
    // Enables for streams 0 to 31
    REG_EN_LO = `SCAN_ADDR_W'(0),
    // Enables for streams 32 to 63
    REG_EN_HI = `SCAN_ADDR_W'(4),
    // Match counter, read only
    REG_COUNT = `SCAN_ADDR_W'(8),
    // Write of any value clears the counter
    REG_CLEAR = `SCAN_ADDR_W'(12)
  } reg_addr_t;

endpackage

// ==== logic/scan_regs.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

module scan_regs
  import scan_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  logic [`SCAN_ADDR_W-1:0]      paddr,
  input  logic [31:0]                 pwdata,
  output logic [31:0]                 prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [`SCAN_COUNT_W-1:0]     count,
  output logic [`SCAN_NUM_STREAMS-1:0] en_mask,
  output logic                        count_clr
);

  reg_addr_t   addr;
  logic        addr_ok;
  logic        access;
  logic        wr_en;
  logic [31:0] en_lo;
  logic [31:0] en_hi;

  assign addr   = reg_addr_t'(paddr);
  // Access phase of a transfer
  assign access = psel && penable;
  assign wr_en  = access && pwrite;

  // Zero wait states
  assign pready = 1'b1;

  // Read mux and address check
  always_comb
  begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (addr)
      REG_EN_LO: prdata = en_lo;
      REG_EN_HI: prdata = en_hi;
      REG_COUNT: prdata = {{(32-`SCAN_COUNT_W){1'b0}}, count};
      // Clear register reads as zero
      REG_CLEAR: prdata = '0;
      default:   addr_ok = 1'b0;
    endcase
  end

  // Error only during the access cycle of an unmapped address
  assign pslverr = access && !addr_ok;

  // Enable words and counter clear pulse
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      en_lo     <= '0;
      en_hi     <= '0;
      count_clr <= 1'b0;
    end
    else
    begin
      count_clr <= wr_en && (addr == REG_CLEAR);
      if (wr_en && (addr == REG_EN_LO))
        en_lo <= pwdata;
      if (wr_en && (addr == REG_EN_HI))
        en_hi <= pwdata;
    end
  end

  // Stream 0 in bit 0
  assign en_mask = {en_hi, en_lo};

  // APB access phase only inside a selected transfer
  assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
    else $error("scan_regs: penable without psel");

endmodule

// ==== logic/smtp_scan_top.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

module smtp_scan_top
  import scan_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // Character bus
  input  char_t                  ch,
  input  logic                   ch_vld,
  input  logic                   load_state,
  input  logic                   eop,
  input  logic [`SCAN_STREAM_W-1:0] stream_id,
  input  logic                   new_stream_id,
  // APB
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`SCAN_ADDR_W-1:0] paddr,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   fired
);

  logic [`SCAN_COUNT_W-1:0]     count;
  logic [`SCAN_NUM_STREAMS-1:0] en_mask;
  logic                        count_clr;
  // Matcher to DFA
  char_t                       ch_r;
  logic                        ch_vld_r;
  dfa_state_t                  state_load;
  logic                        load_vld;
  dfa_state_t                  dfa_state;
  logic                        dfa_accept;

  // Source side of the bus is the top level ports
  char_stream_if bus_if ();

  assign bus_if.ch            = ch;
  assign bus_if.ch_vld        = ch_vld;
  assign bus_if.load_state    = load_state;
  assign bus_if.eop           = eop;
  assign bus_if.stream_id     = stream_id;
  assign bus_if.new_stream_id = new_stream_id;

  scan_regs scan_regs_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .count     (count),
    .en_mask   (en_mask),
    .count_clr (count_clr)
  );

  stream_matcher stream_matcher_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus_if.sink),
    .en_mask    (en_mask),
    .count_clr  (count_clr),
    .count      (count),
    .fired      (fired),
    .ch_r       (ch_r),
    .ch_vld_r   (ch_vld_r),
    .state_load (state_load),
    .load_vld   (load_vld),
    .dfa_state  (dfa_state),
    .dfa_accept (dfa_accept)
  );

  mail_dfa mail_dfa_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .ch         (ch_r),
    .ch_vld     (ch_vld_r),
    .state_load (state_load),
    .load_vld   (load_vld),
    .state      (dfa_state),
    .accept     (dfa_accept)
  );

endmodule

// ==== logic/stream_matcher.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

module stream_matcher
  import scan_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  char_stream_if.sink                 bus,
  input  logic [`SCAN_NUM_STREAMS-1:0] en_mask,
  input  logic                        count_clr,
  output logic [`SCAN_COUNT_W-1:0]     count,
  output logic                        fired,
  // Towards the DFA
  output char_t                       ch_r,
  output logic                        ch_vld_r,
  output dfa_state_t                  state_load,
  output logic                        load_vld,
  input  dfa_state_t                  dfa_state,
  input  logic                        dfa_accept
);

  // Saved DFA state per stream
  dfa_state_t state_mem [`SCAN_NUM_STREAMS];

  // Restore state latched one cycle after load_state
  dfa_state_t restore_state;
  logic       restore_vld;

  // Registered DFA outputs
  dfa_state_t state_r;
  logic       accept_r;
  // DFA stepped on a character in the previous cycle
  logic       step_vld;

  // Packet saw at least one match
  logic       spec_match;
  // Between load_state and eop
  logic       in_pkt;
  logic       stream_en;
  dfa_state_t save_state;

  assign stream_en = en_mask[bus.stream_id];

  // A finished match continues exactly like idle
  // Storing S_IDLE keeps the next packet from accepting before its first byte
  assign save_state = (state_r == S_HIT) ? S_IDLE : state_r;

  assign fired = spec_match;

  // Pick the restore state when the packet starts
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      restore_vld <= 1'b0;
    else
      restore_vld <= bus.load_state;
  end

  always_ff @(posedge clk)
  begin
    if (bus.load_state)
    begin
      // Unknown stream starts clean
      if (bus.new_stream_id)
        restore_state <= S_IDLE;
      else
        restore_state <= state_mem[bus.stream_id];
    end
  end

  // Register everything around the DFA for timing
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ch_vld_r <= 1'b0;
      step_vld <= 1'b0;
      load_vld <= 1'b0;
      accept_r <= 1'b0;
    end
    else
    begin
      ch_vld_r <= bus.ch_vld;
      step_vld <= ch_vld_r;
      load_vld <= restore_vld;
      // Only an accept reached by a character step counts
      // A DFA left in S_HIT by the previous packet is ignored
      accept_r <= dfa_accept && step_vld;
    end
  end

  always_ff @(posedge clk)
  begin
    ch_r       <= bus.ch;
    state_load <= restore_state;
    state_r    <= dfa_state;
  end

  // Match flag and global counter
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      spec_match <= 1'b0;
      count      <= '0;
    end
    else
    begin
      // Fresh flag for every packet
      if (bus.load_state)
        spec_match <= 1'b0;
      // Any accept in the packet marks it
      if (accept_r)
        spec_match <= 1'b1;
      // Disabled stream only drops the flag
      if (bus.eop && !stream_en)
        spec_match <= 1'b0;
      // Clear wins over a same-cycle eop
      if (count_clr)
        count <= '0;
      else if (bus.eop && stream_en)
        count <= count + {{(`SCAN_COUNT_W-1){1'b0}}, spec_match};
    end
  end

  // Save the DFA state at eop of an enabled stream
  always_ff @(posedge clk)
  begin
    if (bus.eop && stream_en)
      state_mem[bus.stream_id] <= save_state;
  end

  // Packet window tracking for the stream id check
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      in_pkt <= 1'b0;
    else if (bus.load_state)
      in_pkt <= 1'b1;
    else if (bus.eop)
      in_pkt <= 1'b0;
  end

  // Save and restore assume one stream per packet
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_pkt && !bus.load_state) |-> $stable(bus.stream_id))
    else $error("stream_matcher: stream_id changed inside a packet");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the scanner testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_smtp_scan \
  -o tb_smtp_scan_sim || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_smtp_scan_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== test/tb_smtp_scan.sv ====
`timescale 1ns/100ps
`include "scan_cfg.svh"

module tb_smtp_scan
  import scan_pkg::*;
();

  // Minimum bus gaps plus one idle cycle
  localparam int LOAD_GAP = 3;
  localparam int EOP_GAP  = 4;
  localparam int APB_TMO  = 16;

  logic                      clk = 1'b0;
  logic                      rst_n;
  // Character bus
  char_t                     ch;
  logic                      ch_vld;
  logic                      load_state;
  logic                      eop;
  logic [`SCAN_STREAM_W-1:0] stream_id;
  logic                      new_stream_id;
  // APB
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`SCAN_ADDR_W-1:0]   paddr;
  logic [31:0]               pwdata;
  logic [31:0]               prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      fired;

  // Packet table with one entry per row
  logic [`SCAN_STREAM_W-1:0] tbl_stream [$];
  bit                        tbl_new [$];
  string                     tbl_data [$];
  bit                        tbl_fired [$];

  // Reference model of the scanner
  dfa_state_t                   model_state [`SCAN_NUM_STREAMS];
  logic [`SCAN_NUM_STREAMS-1:0] model_en;
  logic [`SCAN_COUNT_W-1:0]     model_count;

  int          mismatches;
  int          failures;
  logic [31:0] lcg_seed = 32'h2fdf8299;

  always #10 clk = ~clk;

  smtp_scan_top smtp_scan_top_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .ch            (ch),
    .ch_vld        (ch_vld),
    .load_state    (load_state),
    .eop           (eop),
    .stream_id     (stream_id),
    .new_stream_id (new_stream_id),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .fired         (fired)
  );

  function automatic logic [31:0] lcg_next();
    lcg_seed = lcg_seed * 32'd1664525 + 32'd1013904223;
    return lcg_seed;
  endfunction

  // Random payload byte that can never start the word
  function automatic char_t filler_byte();
    logic [31:0] r;
    char_t       b;
    r = lcg_next();
    b = r[31:24];
    if (b == "M")
      b = "N";
    return b;
  endfunction

  // One DFA step where each state counts the letters of MAIL seen so far
  function automatic dfa_state_t model_step(dfa_state_t s, char_t c);
    string word;
    word = "MAIL";
    if (s != S_HIT && c == word[int'(s)])
      return dfa_state_t'(int'(s) + 1);
    // An M after a broken prefix starts over at the first letter
    if (c == word[0])
      return S_M;
    return S_IDLE;
  endfunction

  // Predicts fired for one packet and updates counter and saved state
  function automatic bit model_packet(logic [`SCAN_STREAM_W-1:0] sid, bit nw,
                                      char_t bytes [$]);
    dfa_state_t s;
    bit         hit;
    s   = nw ? S_IDLE : model_state[sid];
    hit = 1'b0;
    foreach (bytes[i])
    begin
      s = model_step(s, bytes[i]);
      if (s == S_HIT)
        hit = 1'b1;
    end
    // Disabled stream keeps the older saved state
    if (model_en[sid])
    begin
      if (hit)
        model_count++;
      model_state[sid] = s;
    end
    return hit;
  endfunction

  task automatic add_pkt(input int sid, input bit nw, input string data, input bit exp);
    tbl_stream.push_back(sid[`SCAN_STREAM_W-1:0]);
    tbl_new.push_back(nw);
    tbl_data.push_back(data);
    tbl_fired.push_back(exp);
  endtask

  // Stream, new-stream flag, payload, fired at eop
  task automatic build_table();
    add_pkt(1, 1'b1, "MAIL FROM:<a@b>", 1'b1);
    add_pkt(1, 1'b1, "MAIL MAIL.", 1'b1);
    add_pkt(1, 1'b1, "RCPT MA", 1'b0);
    add_pkt(1, 1'b0, "IL TO", 1'b1);
    add_pkt(1, 1'b1, "xxMA", 1'b0);
    add_pkt(1, 1'b1, "IL TO", 1'b0);
    add_pkt(5, 1'b1, "DATA MA", 1'b0);
    add_pkt(5, 1'b0, "MAIL x", 1'b1);
    add_pkt(5, 1'b0, "IL!", 1'b1);
    add_pkt(3, 1'b1, "HELO MA", 1'b0);
    add_pkt(40, 1'b1, "QUIT M", 1'b0);
    add_pkt(3, 1'b0, "I", 1'b0);
    add_pkt(40, 1'b0, "AI", 1'b0);
    add_pkt(3, 1'b0, "L?", 1'b1);
    add_pkt(40, 1'b0, "L?", 1'b1);
    add_pkt(40, 1'b1, "MAIL;", 1'b1);
    add_pkt(1, 1'b1, "RCPT MAIL", 1'b1);
    add_pkt(3, 1'b1, "NOOP", 1'b0);
  endtask

  task automatic check_count(input logic [`SCAN_COUNT_W-1:0] got,
                             input logic [`SCAN_COUNT_W-1:0] exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s count %0d expected %0d", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_fired(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s fired %b expected %b", $time, what, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_apb(input logic [31:0] got, input logic got_err,
                           input logic [31:0] exp, input logic exp_err, input string what);
    if (got !== exp || got_err !== exp_err)
    begin
      $display("Mismatch at %0t: %s prdata %h pslverr %b expected %h %b",
               $time, what, got, got_err, exp, exp_err);
      mismatches++;
    end
  endtask

  // Bounded idle time on the bus
  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(negedge clk);
  endtask

  // Setup phase followed by the access phase until pready
  task automatic apb_xfer(input bit wr, input logic [`SCAN_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    @(posedge clk);
    while (!pready && waited < APB_TMO)
    begin
      @(posedge clk);
      waited++;
    end
    if (!pready)
    begin
      $display("APB transfer to address %0h did not complete in %0d cycles", addr, APB_TMO);
      failures++;
    end
    else if (waited != 0)
    begin
      $display("APB transfer to address %0h took %0d wait states", addr, waited);
      failures++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`SCAN_ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err, input string what);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    // A write is judged by its error response alone
    check_apb(32'h0, err, 32'h0, exp_err, what);
  endtask

  task automatic apb_check_read(input logic [`SCAN_ADDR_W-1:0] addr, input logic [31:0] exp,
                                input logic exp_err, input string what);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    check_apb(rd, err, exp, exp_err, what);
  endtask

  task automatic read_count(input string what);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, REG_COUNT, 32'h0, rd, err);
    check_count(rd[`SCAN_COUNT_W-1:0], model_count, what);
    if (err || rd[31:`SCAN_COUNT_W] != '0)
    begin
      $display("Counter read during %s returned an error or nonzero upper bits", what);
      failures++;
    end
  endtask

  task automatic set_enables(input logic [31:0] lo, input logic [31:0] hi);
    apb_write(REG_EN_LO, lo, 1'b0, "enable low write");
    apb_write(REG_EN_HI, hi, 1'b0, "enable high write");
    model_en = {hi, lo};
  endtask

  // load_state, gap, characters, gap, eop with the fired check
  task automatic drive_packet(input logic [`SCAN_STREAM_W-1:0] sid, input bit nw,
                              input char_t bytes [$], input bit exp_fired,
                              input string what);
    @(negedge clk);
    stream_id     = sid;
    new_stream_id = nw;
    load_state    = 1'b1;
    @(negedge clk);
    load_state    = 1'b0;
    new_stream_id = 1'b0;
    idle_cycles(LOAD_GAP - 1);
    foreach (bytes[i])
    begin
      ch     = bytes[i];
      ch_vld = 1'b1;
      @(negedge clk);
    end
    ch_vld = 1'b0;
    idle_cycles(EOP_GAP - 1);
    eop = 1'b1;
    // Flag must already be up when eop is on the bus
    check_fired(fired, exp_fired, what);
    @(negedge clk);
    eop = 1'b0;
  endtask

  task automatic run_rows(input int first, input int last);
    char_t bytes [$];
    string s;
    bit    hit;
    for (int r = first; r <= last; r++)
    begin
      s = tbl_data[r];
      bytes.delete();
      for (int i = 0; i < s.len(); i++)
        bytes.push_back(s[i]);
      hit = model_packet(tbl_stream[r], tbl_new[r], bytes);
      if (hit != tbl_fired[r])
      begin
        $display("Table row %0d expects fired %0b but the model predicts %0b",
                 r, tbl_fired[r], hit);
        failures++;
      end
      drive_packet(tbl_stream[r], tbl_new[r], bytes, tbl_fired[r], $sformatf("row %0d", r));
    end
  endtask

  // Fresh random streams with payloads free of any M
  task automatic run_filler(input int n);
    char_t                     bytes [$];
    logic [31:0]               r;
    logic [`SCAN_STREAM_W-1:0] sid;
    int                        len;
    bit                        hit;
    for (int p = 0; p < n; p++)
    begin
      r   = lcg_next();
      sid = r[31:32-`SCAN_STREAM_W];
      len = 4 + int'(r[19:16]);
      bytes.delete();
      for (int i = 0; i < len; i++)
        bytes.push_back(filler_byte());
      hit = model_packet(sid, 1'b1, bytes);
      drive_packet(sid, 1'b1, bytes, hit, $sformatf("filler %0d", p));
    end
  endtask

  initial
  begin
    rst_n         = 1'b0;
    ch            = '0;
    ch_vld        = 1'b0;
    load_state    = 1'b0;
    eop           = 1'b0;
    stream_id     = '0;
    new_stream_id = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    mismatches    = 0;
    failures      = 0;
    model_count   = '0;
    model_en      = '0;
    foreach (model_state[i])
      model_state[i] = S_IDLE;
    build_table();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Clean state out of reset
    @(negedge clk);
    check_fired(fired, 1'b0, "after reset");
    read_count("after reset");
    apb_check_read(REG_EN_LO, 32'h0, 1'b0, "enable low after reset");

    // Streams 1, 3, 5 and 40
    set_enables(32'h0000_002A, 32'h0000_0100);
    run_rows(0, 0);
    read_count("single MAIL");
    run_rows(1, 1);
    read_count("MAIL twice in one packet");
    run_rows(2, 5);
    read_count("split across packets");

    // Stream 5 is off for one packet and back on afterwards
    run_rows(6, 6);
    set_enables(32'h0000_000A, 32'h0000_0100);
    run_rows(7, 7);
    read_count("disabled stream");
    set_enables(32'h0000_002A, 32'h0000_0100);
    run_rows(8, 8);
    read_count("resume from older state");

    run_rows(9, 14);
    read_count("interleaved streams");

    // Register map
    apb_write(REG_CLEAR, 32'hFFFF_FFFF, 1'b0, "clear write");
    model_count = '0;
    read_count("after clear");
    apb_check_read(REG_CLEAR, 32'h0, 1'b0, "clear register read");
    set_enables(32'h0000_002A, 32'hA5A5_0100);
    apb_check_read(REG_EN_HI, 32'hA5A5_0100, 1'b0, "enable high readback");
    apb_check_read(`SCAN_ADDR_W'(2), 32'h0, 1'b1, "unmapped read");
    apb_write(`SCAN_ADDR_W'(2), 32'h1234_5678, 1'b1, "unmapped write");

    run_filler(6);
    read_count("filler packets");
    run_rows(15, 15);
    read_count("count after clear");

    // A match on the last byte must not leak into the next packet
    run_rows(16, 17);
    read_count("match ending a packet");

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
